// ==== eeprom_subsystem.f ====
+incdir+include
verilog/eeprom_pkg.sv
verilog/apb_eeprom_regs.sv
verilog/i2c_master.sv
verilog/eeprom_slave.sv
verilog/eeprom_subsystem.sv
tests/eeprom_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the EEPROM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module eeprom_subsystem_tb \
    -f eeprom_subsystem.f -o eeprom_sim \
    && ./obj_dir/eeprom_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1

// ==== tests/eeprom_subsystem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_subsystem_tb;
    import eeprom_pkg::*;

    localparam int        CLK_NS  = 20;
    localparam int        N_OPS   = 28;
    // Longest operation is 40 bit periods
    localparam int        OP_CYC  = 40 * 4 * `EEPROM_QTR;
    localparam int        WDOG_NS = N_OPS * OP_CYC * CLK_NS + 50000;
    localparam dev_type_t DEV     = `EEPROM_DEV_TYPE;

    logic        scl;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         irq;
    wire         bus_clk;
    wire         bus_data;

    integer      seed;
    int          errors;
    byte_t       exp_mem [0:2047];

    // Expected values for the checkers below
    logic        rd_chk;
    logic [31:0] rd_mask;
    logic [31:0] rd_exp;
    logic        err_exp;
    logic        rst_chk;

    // Bus monitor state
    logic        clk_q;
    logic        data_q;
    int          rise_cnt;

    eeprom_subsystem uut (
        .scl      (scl),
        .arst_n   (arst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .irq      (irq),
        .bus_clk  (bus_clk),
        .bus_data (bus_data)
    );

    initial
    begin
        scl = 1'b0;
        forever #(CLK_NS / 2) scl = ~scl;
    end

    // Rising bus clocks since the last start or stop
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_q    <= 1'b1;
            data_q   <= 1'b1;
            rise_cnt <= 0;
        end
        else
        begin
            clk_q  <= bus_clk;
            data_q <= bus_data;
            if (bus_clk && clk_q && (bus_data != data_q))
                rise_cnt <= 0;
            else if (bus_clk && !clk_q)
                rise_cnt <= rise_cnt + 1;
        end
    end

    a_prdata: assert property (@(posedge scl)
        (psel && penable && !pwrite && rd_chk) |-> ((prdata & rd_mask) == rd_exp))
    else
    begin
        errors++;
        $display("CHECK FAILED prdata: got %h, expected %h under mask %h",
            $sampled(prdata), $sampled(rd_exp), $sampled(rd_mask));
    end

    a_pslverr: assert property (@(posedge scl)
        (psel && penable && pwrite) |-> (pslverr == err_exp))
    else
    begin
        errors++;
        $display("CHECK FAILED pslverr: got %h, expected %h",
            $sampled(pslverr), $sampled(err_exp));
    end

    a_pready: assert property (@(posedge scl) (psel && penable) |-> pready)
    else
    begin
        errors++;
        $display("CHECK FAILED pready: got %h, expected 1", $sampled(pready));
    end

    a_reset_lines: assert property (@(posedge scl)
        rst_chk |-> (bus_clk && bus_data && !irq))
    else
    begin
        errors++;
        $display("CHECK FAILED bus_clk/bus_data/irq: got %h/%h/%h, expected 1/1/0",
            $sampled(bus_clk), $sampled(bus_data), $sampled(irq));
    end

    // Start, restart and stop only fall on byte boundaries
    a_bus_frame: assert property (@(posedge scl) disable iff (!arst_n)
        (bus_clk && clk_q && (bus_data != data_q)) |-> (rise_cnt == 0 || rise_cnt % 9 == 1))
    else
    begin
        errors++;
        $display("Data line changed while the bus clock was high inside a byte");
    end

    a_idle_lines: assert property (@(posedge scl) disable iff (!arst_n)
        !uut.busy |-> (bus_clk && bus_data))
    else
    begin
        errors++;
        $display("Bus lines were not both high while the master was idle");
    end

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        @(negedge scl);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge scl);
        penable = 1'b1;
        @(negedge scl);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic [31:0] mask,
                            input logic [31:0] exp);
        @(negedge scl);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge scl);
        penable = 1'b1;
        rd_chk  = 1'b1;
        rd_mask = mask;
        rd_exp  = exp;
        @(negedge scl);
        psel    = 1'b0;
        penable = 1'b0;
        rd_chk  = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge scl);
        while (!irq)
            @(negedge scl);
    endtask

    task automatic eeprom_write(input mem_addr_t addr, input byte_t data);
        apb_write(`EEPROM_REG_ADDR, {21'd0, addr});
        apb_write(`EEPROM_REG_WDATA, {24'd0, data});
        apb_write(`EEPROM_REG_CTRL, {24'd0, DEV, 4'b0001});
        wait_done();
        apb_read(`EEPROM_REG_STATUS, 32'h0000_0007, 32'h0000_0002);
        exp_mem[addr] = data;
    endtask

    task automatic eeprom_read(input mem_addr_t addr);
        apb_write(`EEPROM_REG_ADDR, {21'd0, addr});
        apb_write(`EEPROM_REG_CTRL, {24'd0, DEV, 4'b0011});
        wait_done();
        apb_read(`EEPROM_REG_STATUS, 32'h0000_FF07, {16'd0, exp_mem[addr], 8'h02});
    endtask

    initial
    begin
        #(WDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        mem_addr_t addr_a;
        mem_addr_t old_addr;
        byte_t     data_a;
        byte_t     word_b;
        byte_t     base_b;

        seed    = 54482;
        errors  = 0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rd_chk  = 1'b0;
        rd_mask = '0;
        rd_exp  = '0;
        err_exp = 1'b0;
        rst_chk = 1'b0;
        // Array starts all zero
        for (int i = 0; i < 2048; i++)
            exp_mem[i] = '0;
        arst_n = 1'b0;
        repeat (8) @(negedge scl);
        arst_n  = 1'b1;
        rst_chk = 1'b1;
        @(negedge scl);
        rst_chk = 1'b0;
        apb_read(`EEPROM_REG_STATUS, 32'hFFFF_FFFF, 32'h0000_0000);

        // Random write then read pairs
        old_addr = mem_addr_t'($random(seed));
        for (int n = 0; n < 4; n++)
        begin
            addr_a = (n == 0) ? old_addr : mem_addr_t'($random(seed));
            data_a = byte_t'($random(seed));
            eeprom_write(addr_a, data_a);
            eeprom_read(addr_a);
        end

        // Same word address in all eight blocks
        word_b = byte_t'($random(seed));
        base_b = byte_t'($random(seed));
        for (int k = 0; k < 8; k++)
            eeprom_write({3'(k), word_b}, base_b ^ {3'(k), 5'd0});
        for (int k = 0; k < 8; k++)
            eeprom_read({3'(k), word_b});

        // Foreign device type writing a different byte over a stored one
        apb_write(`EEPROM_REG_ADDR, {21'd0, old_addr});
        apb_write(`EEPROM_REG_WDATA, {24'd0, ~exp_mem[old_addr]});
        apb_write(`EEPROM_REG_CTRL, {24'd0, DEV ^ 4'b0001, 4'b0001});
        wait_done();
        apb_read(`EEPROM_REG_STATUS, 32'h0000_0007, 32'h0000_0006);
        eeprom_read(old_addr);

        // CTRL write refused while busy
        addr_a = mem_addr_t'($random(seed));
        data_a = byte_t'($random(seed));
        apb_write(`EEPROM_REG_ADDR, {21'd0, addr_a});
        apb_write(`EEPROM_REG_WDATA, {24'd0, data_a});
        apb_write(`EEPROM_REG_CTRL, {24'd0, DEV, 4'b0001});
        apb_read(`EEPROM_REG_STATUS, 32'h0000_0001, 32'h0000_0001);
        err_exp = 1'b1;
        apb_write(`EEPROM_REG_CTRL, {24'd0, DEV ^ 4'b0001, 4'b0011});
        err_exp = 1'b0;
        wait_done();
        apb_read(`EEPROM_REG_STATUS, 32'h0000_0007, 32'h0000_0002);
        exp_mem[addr_a] = data_a;
        eeprom_read(addr_a);

        repeat (4) @(negedge scl);
        $display("Tests finished with %0d errors", errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/eeprom_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module eeprom_subsystem (
    input  wire                        scl,
    input  wire                        arst_n,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire eeprom_pkg::apb_addr_t paddr,
    input  wire [31:0]                 pwdata,
    output wire [31:0]                 prdata,
    output wire                        pready,
    output wire                        pslverr,
    output wire                        irq,
    output wire                        bus_clk,
    output wire                        bus_data
);
    import eeprom_pkg::*;

    wire       busy;
    wire       cmd_start;
    wire       cmd_read;
    wire       cmd_done;
    wire       cmd_nack;
    dev_type_t cmd_dev;
    mem_addr_t cmd_addr;
    byte_t     cmd_wdata;
    byte_t     cmd_rdata;
    wire       master_sda_low;
    wire       slave_sda_low;

    // Pull-up on the data line with two open-drain drivers
    assign bus_data = !master_sda_low && !slave_sda_low;

    apb_eeprom_regs u_regs (
        .scl       (scl),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .busy      (busy),
        .cmd_done  (cmd_done),
        .cmd_nack  (cmd_nack),
        .cmd_rdata (cmd_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .irq       (irq),
        .cmd_start (cmd_start),
        .cmd_read  (cmd_read),
        .cmd_dev   (cmd_dev),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata)
    );

    i2c_master u_master (
        .scl            (scl),
        .arst_n         (arst_n),
        .cmd_start      (cmd_start),
        .cmd_read       (cmd_read),
        .cmd_dev        (cmd_dev),
        .cmd_addr       (cmd_addr),
        .cmd_wdata      (cmd_wdata),
        .bus_data       (bus_data),
        .busy           (busy),
        .cmd_done       (cmd_done),
        .cmd_nack       (cmd_nack),
        .cmd_rdata      (cmd_rdata),
        .bus_clk        (bus_clk),
        .master_sda_low (master_sda_low)
    );

    eeprom_slave u_slave (
        .scl           (scl),
        .arst_n        (arst_n),
        .bus_clk       (bus_clk),
        .bus_data      (bus_data),
        .slave_sda_low (slave_sda_low)
    );

endmodule

`default_nettype wire

// ==== verilog/eeprom_slave.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_slave (
    input  wire  scl,
    input  wire  arst_n,
    input  wire  bus_clk,
    input  wire  bus_data,
    output logic slave_sda_low
);
    import eeprom_pkg::*;

    localparam dev_type_t DEV = `EEPROM_DEV_TYPE;

    byte_t        mem [0:2047];
    slave_state_t state;
    logic         clk_q;
    logic         data_q;
    logic [3:0]   bit_cnt;
    logic         acking;
    logic         wr_pend;
    logic [2:0]   blk;
    byte_t        word;
    byte_t        shreg;
    byte_t        wr_data;
    byte_t        rd_byte;
    mem_addr_t    addr;
    logic         start_det;
    logic         stop_det;
    logic         clk_rise;
    logic         clk_fall;
    logic         byte_done;
    logic         data_done;

    assign start_det = bus_clk && clk_q && data_q && !bus_data;
    assign stop_det  = bus_clk && clk_q && !data_q && bus_data;
    assign clk_rise  = bus_clk && !clk_q;
    assign clk_fall  = !bus_clk && clk_q;
    assign byte_done = clk_fall && !acking && (bit_cnt == 4'd8);
    assign data_done = byte_done && (state == S_GET_DATA);
    assign addr      = {blk, word};
    assign rd_byte   = mem[addr];

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = '0;
    end

    // Array update at the stop that closes a write
    always_ff @(posedge scl)
    begin
        if (data_done)
            wr_data <= shreg;
        if (stop_det && wr_pend)
            mem[addr] <= wr_data;
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state         <= S_IDLE;
            clk_q         <= 1'b1;
            data_q        <= 1'b1;
            bit_cnt       <= '0;
            acking        <= 1'b0;
            wr_pend       <= 1'b0;
            blk           <= '0;
            word          <= '0;
            shreg         <= '0;
            slave_sda_low <= 1'b0;
        end
        else
        begin
            clk_q  <= bus_clk;
            data_q <= bus_data;
            if (start_det)
            begin
                state         <= S_GET_CTRL;
                bit_cnt       <= '0;
                acking        <= 1'b0;
                slave_sda_low <= 1'b0;
            end
            else if (stop_det)
            begin
                state         <= S_IDLE;
                acking        <= 1'b0;
                wr_pend       <= 1'b0;
                slave_sda_low <= 1'b0;
            end
            else if (clk_fall && acking)
            begin
                // End of acknowledge; a read puts its first bit out now
                acking <= 1'b0;
                if (state == S_SEND_DATA)
                begin
                    slave_sda_low <= !rd_byte[7];
                    shreg         <= {rd_byte[6:0], 1'b0};
                    bit_cnt       <= 4'd1;
                end
                else
                begin
                    slave_sda_low <= 1'b0;
                    bit_cnt       <= '0;
                end
            end
            else
            begin
                case (state)
                    S_GET_CTRL, S_GET_ADDR, S_GET_DATA:
                    begin
                        if (clk_rise && !acking && bit_cnt != 4'd8)
                        begin
                            shreg   <= {shreg[6:0], bus_data};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (byte_done)
                        begin
                            acking        <= 1'b1;
                            slave_sda_low <= 1'b1;
                            if (state == S_GET_CTRL)
                            begin
                                blk   <= shreg[3:1];
                                state <= shreg[0] ? S_SEND_DATA : S_GET_ADDR;
                                // Foreign device type gets no acknowledge
                                if (shreg[7:4] != DEV)
                                begin
                                    acking        <= 1'b0;
                                    slave_sda_low <= 1'b0;
                                    state         <= S_IDLE;
                                end
                            end
                            else if (state == S_GET_ADDR)
                            begin
                                word  <= shreg;
                                state <= S_GET_DATA;
                            end
                            else
                                wr_pend <= 1'b1;
                        end
                    end
                    S_SEND_DATA:
                    begin
                        if (clk_fall)
                        begin
                            if (bit_cnt != 4'd8)
                            begin
                                slave_sda_low <= !shreg[7];
                                shreg         <= {shreg[6:0], 1'b0};
                                bit_cnt       <= bit_cnt + 1'b1;
                            end
                            else
                            begin
                                slave_sda_low <= 1'b0;
                                state         <= S_WAIT_ACK;
                            end
                        end
                    end
                    // No sequential read, so the master's answer ends it
                    S_WAIT_ACK:
                    begin
                        if (clk_rise)
                            state <= S_IDLE;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_idle_quiet: assert property (@(posedge scl) disable iff (!arst_n)
        (state == S_IDLE) |-> !slave_sda_low)
        else $error("slave pulls data line low while idle");

endmodule

`default_nettype wire

// ==== verilog/i2c_master.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_cfg.svh"

module i2c_master (
    input  wire                        scl,
    input  wire                        arst_n,
    input  wire                        cmd_start,
    input  wire                        cmd_read,
    input  wire eeprom_pkg::dev_type_t cmd_dev,
    input  wire eeprom_pkg::mem_addr_t cmd_addr,
    input  wire eeprom_pkg::byte_t     cmd_wdata,
    input  wire                        bus_data,
    output logic                       busy,
    output logic                       cmd_done,
    output logic                       cmd_nack,
    output eeprom_pkg::byte_t          cmd_rdata,
    output logic                       bus_clk,
    output logic                       master_sda_low
);
    import eeprom_pkg::*;

    localparam int QTR = `EEPROM_QTR;
    localparam int QW  = $clog2(QTR);
    localparam logic [QW-1:0] QLAST = QW'(QTR - 1);

    master_state_t state;
    logic [QW-1:0] qcnt;
    logic [1:0]    ph;
    logic [2:0]    bit_cnt;
    logic [1:0]    step;
    byte_t         tx;
    byte_t         rx;
    logic          ack_ok;
    logic          tick;
    logic          bit_end;
    logic          mid_high;
    logic [6:0]    ctrl_hdr;

    assign tick      = (qcnt == QLAST);
    assign bit_end   = tick && (ph == 2'd3);
    // Clock is high in the two middle quarters of a bit
    assign mid_high  = ph[0] ^ ph[1];
    assign ctrl_hdr  = {cmd_dev, cmd_addr[10:8]};
    assign cmd_rdata = rx;

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= M_IDLE;
            qcnt     <= '0;
            ph       <= '0;
            bit_cnt  <= '0;
            step     <= '0;
            tx       <= '0;
            rx       <= '0;
            ack_ok   <= 1'b0;
            busy     <= 1'b0;
            cmd_done <= 1'b0;
            cmd_nack <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (state == M_IDLE)
            begin
                qcnt <= '0;
                ph   <= '0;
                if (cmd_start)
                begin
                    state    <= M_START;
                    busy     <= 1'b1;
                    cmd_nack <= 1'b0;
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                    ph <= ph + 1'b1;
                // Sample just before the rising bus clock
                if (tick && ph == 2'd0)
                begin
                    if (state == M_GET_ACK)
                        ack_ok <= !bus_data;
                    if (state == M_RECV)
                        rx <= {rx[6:0], bus_data};
                end
                if (bit_end)
                begin
                    case (state)
                        M_START:
                        begin
                            state   <= M_SEND;
                            tx      <= {ctrl_hdr, 1'b0};
                            bit_cnt <= '0;
                            step    <= '0;
                        end
                        M_SEND:
                        begin
                            if (bit_cnt == 3'd7)
                                state <= M_GET_ACK;
                            else
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                                tx      <= {tx[6:0], 1'b0};
                            end
                        end
                        M_GET_ACK:
                        begin
                            bit_cnt <= '0;
                            if (!ack_ok)
                            begin
                                cmd_nack <= 1'b1;
                                state    <= M_STOP;
                            end
                            else
                            begin
                                step <= step + 1'b1;
                                case (step)
                                    2'd0:
                                    begin
                                        tx    <= cmd_addr[7:0];
                                        state <= M_SEND;
                                    end
                                    2'd1:
                                    begin
                                        tx    <= cmd_wdata;
                                        state <= cmd_read ? M_RESTART : M_SEND;
                                    end
                                    default: state <= cmd_read ? M_RECV : M_STOP;
                                endcase
                            end
                        end
                        M_RESTART:
                        begin
                            tx    <= {ctrl_hdr, 1'b1};
                            state <= M_SEND;
                        end
                        M_RECV:
                        begin
                            if (bit_cnt == 3'd7)
                                state <= M_SEND_NACK;
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                        M_SEND_NACK: state <= M_STOP;
                        default:
                        begin
                            state    <= M_IDLE;
                            busy     <= 1'b0;
                            cmd_done <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_comb
    begin
        bus_clk        = 1'b1;
        master_sda_low = 1'b0;
        case (state)
            M_START:
            begin
                bus_clk        = (ph != 2'd3);
                master_sda_low = (ph != 2'd0);
            end
            M_SEND:
            begin
                bus_clk        = mid_high;
                master_sda_low = !tx[7];
            end
            M_GET_ACK, M_RECV, M_SEND_NACK: bus_clk = mid_high;
            M_RESTART:
            begin
                bus_clk        = mid_high;
                master_sda_low = ph[1];
            end
            M_STOP:
            begin
                bus_clk        = (ph != 2'd0);
                master_sda_low = !ph[1];
            end
            default: ;
        endcase
    end

    // Both drivers of the line keep to the low clock phase
    a_sda_stable: assert property (@(posedge scl) disable iff (!arst_n)
        $changed(bus_data) |-> !bus_clk || (state inside {M_START, M_RESTART, M_STOP}))
        else $error("data line changed while bus clock high");

endmodule

`default_nettype wire

// ==== verilog/apb_eeprom_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_cfg.svh"

module apb_eeprom_regs (
    input  wire                    scl,
    input  wire                    arst_n,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire eeprom_pkg::apb_addr_t paddr,
    input  wire [31:0]             pwdata,
    input  wire                    busy,
    input  wire                    cmd_done,
    input  wire                    cmd_nack,
    input  wire eeprom_pkg::byte_t cmd_rdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    output logic                   cmd_start,
    output logic                   cmd_read,
    output eeprom_pkg::dev_type_t  cmd_dev,
    output eeprom_pkg::mem_addr_t  cmd_addr,
    output eeprom_pkg::byte_t      cmd_wdata
);
    import eeprom_pkg::*;

    logic  wr_acc;
    logic  ctrl_wr;
    logic  go_ok;
    logic  done_r;
    logic  nack_r;
    byte_t rdata_r;

    assign wr_acc  = psel && penable && pwrite;
    assign ctrl_wr = wr_acc && (paddr == `EEPROM_REG_CTRL);
    // Start pulse counts as busy until the master answers
    assign pslverr = ctrl_wr && (busy || cmd_start);
    assign go_ok   = ctrl_wr && !pslverr && pwdata[0];
    assign pready  = 1'b1;
    assign irq     = done_r;

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cmd_start <= 1'b0;
            cmd_read  <= 1'b0;
            cmd_dev   <= '0;
            done_r    <= 1'b0;
            nack_r    <= 1'b0;
            rdata_r   <= '0;
        end
        else
        begin
            cmd_start <= go_ok;
            if (ctrl_wr && !pslverr)
            begin
                cmd_read <= pwdata[1];
                cmd_dev  <= pwdata[7:4];
            end
            if (go_ok)
            begin
                done_r <= 1'b0;
                nack_r <= 1'b0;
            end
            else if (cmd_done)
            begin
                done_r  <= 1'b1;
                nack_r  <= cmd_nack;
                rdata_r <= cmd_rdata;
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (wr_acc && paddr == `EEPROM_REG_ADDR)
            cmd_addr <= pwdata[10:0];
        if (wr_acc && paddr == `EEPROM_REG_WDATA)
            cmd_wdata <= pwdata[7:0];
    end

    always_comb
    begin
        case (paddr)
            `EEPROM_REG_ADDR:   prdata = {21'd0, cmd_addr};
            `EEPROM_REG_WDATA:  prdata = {24'd0, cmd_wdata};
            `EEPROM_REG_CTRL:   prdata = {24'd0, cmd_dev, 2'd0, cmd_read, 1'b0};
            `EEPROM_REG_STATUS: prdata = {16'd0, rdata_r, 5'd0, nack_r, done_r, busy};
            default:            prdata = '0;
        endcase
    end

    // Master must be idle at a start and pick it up one cycle later
    a_start_idle: assert property (@(posedge scl) disable iff (!arst_n)
        cmd_start |-> !busy ##1 busy)
        else $error("cmd_start issued while master busy or not taken");

endmodule

`default_nettype wire

// ==== verilog/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // Block bits in 10:8, word address byte below
    typedef logic [10:0] mem_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  dev_type_t;
    typedef logic [3:0]  apb_addr_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_SEND,
        M_GET_ACK,
        M_RESTART,
        M_RECV,
        M_SEND_NACK,
        M_STOP
    } master_state_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_GET_CTRL,
        S_GET_ADDR,
        S_GET_DATA,
        S_SEND_DATA,
        S_WAIT_ACK
    } slave_state_t;

endpackage

`default_nettype wire

// ==== include/eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// System clock cycles per quarter of a bus clock period, 2 or more
`define EEPROM_QTR 4

// Device type field the EEPROM answers to
`define EEPROM_DEV_TYPE 4'b1010

// APB register byte offsets
`define EEPROM_REG_ADDR   4'h0
`define EEPROM_REG_WDATA  4'h4
`define EEPROM_REG_CTRL   4'h8
`define EEPROM_REG_STATUS 4'hC

`endif
